// File: Makefile
# Verilator build and run for the usb3 PIPE3 data path

VERILATOR ?= verilator
TOP       ?= tb_usb3_pipe_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/link_skid.sv
// link side skid buffer
// two entries, a main and a skid register, one transfer per cycle each way

`timescale 1ns/10ps

`include "usb3_macros.svh"

module link_skid #(
	parameter type payload_t = usb3_pkg::link_word_t
) (
	input  logic     local_pclk_half,
	input  logic     core_rst_n,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	localparam int ENTRIES = `USB3_SKID_DEPTH;
	localparam int FILL_W  = $clog2(ENTRIES + 1);

	payload_t          skid_data;
	logic              skid_valid;
	logic              in_fire;
	logic              out_fire;
	logic              load_main;   // main register free on this edge
	logic              main_v_nxt;
	logic              skid_v_nxt;
	logic [FILL_W-1:0] fill_nxt;

	assign in_fire  = in_valid & in_ready;
	assign out_fire = out_valid & out_ready;

	assign load_main = ~out_valid | out_fire;

	////////////////////////////////////////
	// next occupancy
	////////////////////////////////////////

	always_comb begin
		if (load_main)
			main_v_nxt = skid_valid | in_fire;
		else
			main_v_nxt = 1'b1;

		if (skid_valid)
			skid_v_nxt = ~load_main;           // drains into main when it frees
		else
			skid_v_nxt = in_fire & ~load_main; // catch the word main cannot take

		fill_nxt = FILL_W'(main_v_nxt) + FILL_W'(skid_v_nxt);
	end

	// control flops, in_ready registered so nothing passes through combinationally
	always_ff @(posedge local_pclk_half or negedge core_rst_n) begin
		if (!core_rst_n) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
			in_ready   <= 1'b1;    // empty buffer takes a word
		end else begin
			out_valid  <= main_v_nxt;
			skid_valid <= skid_v_nxt;
			in_ready   <= (fill_nxt < FILL_W'(ENTRIES));
		end
	end

	// payload
	always_ff @(posedge local_pclk_half) begin
		if (load_main) begin
			if (skid_valid)
				out_data <= skid_data;  // oldest word first
			else if (in_fire)
				out_data <= in_data;
		end
		if (in_fire && !load_main)
			skid_data <= in_data;
	end

endmodule

// File: hdl/pipe_rx_packer.sv
// PIPE receive packer
// pairs 16 bit beats into 32 bit link words, flags overflow when the link stalls

`timescale 1ns/10ps

`include "usb3_macros.svh"

module pipe_rx_packer (
	input  logic                 local_pclk_half,
	input  logic                 core_rst_n,
	input  usb3_pkg::pipe_beat_t rx_beat,
	input  logic                 rx_beat_valid,
	output usb3_pkg::link_word_t rx_word,
	output logic                 rx_word_valid,
	input  logic                 rx_word_ready,
	output logic                 rx_overflow
);

	import usb3_pkg::*;

	pipe_beat_t lo_beat;        // first beat of the pair
	logic       phase;          // 1 once the low beat is stored
	logic       pair_done;
	logic       slot_free;

	// invalid beats neither advance nor break a pair
	assign pair_done = rx_beat_valid & phase;
	assign slot_free = ~rx_word_valid | rx_word_ready;

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	always_ff @(posedge local_pclk_half or negedge core_rst_n) begin
		if (!core_rst_n) begin
			phase         <= 1'b0;
			rx_word_valid <= 1'b0;
			rx_overflow   <= 1'b0;
		end else begin
			if (rx_beat_valid)
				phase <= ~phase;

			if (rx_word_valid && rx_word_ready)
				rx_word_valid <= 1'b0;

			if (pair_done) begin
				if (slot_free)
					rx_word_valid <= 1'b1;
				else
					rx_overflow <= 1'b1;  // sticky, new word is dropped
			end
		end
	end

	////////////////////////////////////////
	// data
	////////////////////////////////////////

	always_ff @(posedge local_pclk_half) begin
		if (rx_beat_valid && !phase)
			lo_beat <= rx_beat;

		// held word only changes once it has been taken
		if (pair_done && slot_free) begin
			rx_word.data[`USB3_PIPE_W-1:0]             <= lo_beat.data;
			rx_word.data[`USB3_LINK_W-1:`USB3_PIPE_W]  <= rx_beat.data;
			rx_word.datak[`USB3_PIPE_K_W-1:0]          <= lo_beat.datak;
			rx_word.datak[`USB3_LINK_K_W-1:`USB3_PIPE_K_W] <= rx_beat.datak;
		end
	end

endmodule

// File: hdl/pipe_tx_serializer.sv
// PIPE transmit serializer
// splits each link word into low then high beat, logical idle in between words

`timescale 1ns/10ps

`include "usb3_macros.svh"

module pipe_tx_serializer (
	input  logic                      local_pclk_half,
	input  logic                      core_rst_n,
	input  usb3_pkg::link_word_t      tx_word,
	input  logic                      tx_word_valid,
	output logic                      tx_word_ready,
	output logic [`USB3_PIPE_W-1:0]   phy_pipe_tx_data,
	output logic [`USB3_PIPE_K_W-1:0] phy_pipe_tx_datak
);

	import usb3_pkg::*;

	pipe_beat_t hi_beat;    // second half, waits one cycle
	logic       phase;      // low half is on the pins, high half goes next
	logic       accept;

	// ready while idle and while the high half is out, so words go back to back
	assign tx_word_ready = ~phase;
	assign accept        = tx_word_valid & tx_word_ready;

	////////////////////////////////////////
	// output beat
	////////////////////////////////////////

	always_ff @(posedge local_pclk_half or negedge core_rst_n) begin
		if (!core_rst_n) begin
			phase             <= 1'b0;
			phy_pipe_tx_data  <= '0;
			phy_pipe_tx_datak <= '0;
		end else if (phase) begin
			phase             <= 1'b0;
			phy_pipe_tx_data  <= hi_beat.data;
			phy_pipe_tx_datak <= hi_beat.datak;
		end else if (accept) begin
			phase             <= 1'b1;
			phy_pipe_tx_data  <= tx_word.data[`USB3_PIPE_W-1:0];
			phy_pipe_tx_datak <= tx_word.datak[`USB3_PIPE_K_W-1:0];
		end else begin
			// logical idle
			phy_pipe_tx_data  <= '0;
			phy_pipe_tx_datak <= '0;
		end
	end

	// keep the high half until the next beat
	always_ff @(posedge local_pclk_half) begin
		if (accept) begin
			hi_beat.data  <= tx_word.data[`USB3_LINK_W-1:`USB3_PIPE_W];
			hi_beat.datak <= tx_word.datak[`USB3_LINK_K_W-1:`USB3_PIPE_K_W];
		end
	end

endmodule

// File: hdl/usb3_pipe_top.sv
// usb3 PIPE3 top level
// reset and straps, receive packing and transmit serializing with link skid buffers

`timescale 1ns/10ps

`include "usb3_macros.svh"

module usb3_pipe_top (
	input  logic                      local_pclk_half,
	input  logic                      rst_n,
	input  logic                      phy_pwrpresent,

	// PHY reset and straps
	output logic                      phy_reset_n,
	output logic                      phy_phy_reset_n,
	output logic                      strap_oe,
	output logic                      phy_rx_elecidle_strap,
	output logic                      phy_status_strap,
	input  logic [2:0]                tx_margin,
	output logic [2:0]                phy_tx_margin,

	// PIPE receive
	input  logic                      phy_pipe_rx_valid,
	input  logic [`USB3_PIPE_W-1:0]   phy_pipe_rx_data,
	input  logic [`USB3_PIPE_K_W-1:0] phy_pipe_rx_datak,

	// link receive
	output usb3_pkg::link_word_t      link_rx_word,
	output logic                      link_rx_valid,
	input  logic                      link_rx_ready,
	output logic                      rx_overflow,

	// link transmit
	input  usb3_pkg::link_word_t      link_tx_word,
	input  logic                      link_tx_valid,
	output logic                      link_tx_ready,

	// PIPE transmit
	output logic [`USB3_PIPE_W-1:0]   phy_pipe_tx_data,
	output logic [`USB3_PIPE_K_W-1:0] phy_pipe_tx_datak
);

	import usb3_pkg::*;

	logic       core_rst_n;     // synced, drives the whole data path
	pipe_beat_t rx_beat;
	link_word_t rx_word;
	logic       rx_word_valid;
	logic       rx_word_ready;
	link_word_t tx_word;
	logic       tx_word_valid;
	logic       tx_word_ready;

	// PHY needs the full external pulse width
	assign phy_reset_n = rst_n;

	////////////////////////////////////////
	// reset and straps
	////////////////////////////////////////

	usb3_reset_strap u_reset_strap (
		.local_pclk_half       (local_pclk_half),
		.rst_n                 (rst_n),
		.phy_pwrpresent        (phy_pwrpresent),
		.tx_margin             (tx_margin),
		.core_rst_n            (core_rst_n),
		.phy_phy_reset_n       (phy_phy_reset_n),
		.strap_oe              (strap_oe),
		.phy_rx_elecidle_strap (phy_rx_elecidle_strap),
		.phy_status_strap      (phy_status_strap),
		.phy_tx_margin         (phy_tx_margin)
	);

	////////////////////////////////////////
	// receive path
	////////////////////////////////////////

	assign rx_beat.data  = phy_pipe_rx_data;
	assign rx_beat.datak = phy_pipe_rx_datak;

	pipe_rx_packer u_rx_packer (
		.local_pclk_half (local_pclk_half),
		.core_rst_n      (core_rst_n),
		.rx_beat         (rx_beat),
		.rx_beat_valid   (phy_pipe_rx_valid),
		.rx_word         (rx_word),
		.rx_word_valid   (rx_word_valid),
		.rx_word_ready   (rx_word_ready),
		.rx_overflow     (rx_overflow)
	);

	link_skid #(.payload_t(link_word_t)) u_rx_skid (
		.local_pclk_half (local_pclk_half),
		.core_rst_n      (core_rst_n),
		.in_data         (rx_word),
		.in_valid        (rx_word_valid),
		.in_ready        (rx_word_ready),
		.out_data        (link_rx_word),
		.out_valid       (link_rx_valid),
		.out_ready       (link_rx_ready)
	);

	////////////////////////////////////////
	// transmit path
	////////////////////////////////////////

	link_skid #(.payload_t(link_word_t)) u_tx_skid (
		.local_pclk_half (local_pclk_half),
		.core_rst_n      (core_rst_n),
		.in_data         (link_tx_word),
		.in_valid        (link_tx_valid),
		.in_ready        (link_tx_ready),
		.out_data        (tx_word),
		.out_valid       (tx_word_valid),
		.out_ready       (tx_word_ready)
	);

	pipe_tx_serializer u_tx_serializer (
		.local_pclk_half   (local_pclk_half),
		.core_rst_n        (core_rst_n),
		.tx_word           (tx_word),
		.tx_word_valid     (tx_word_valid),
		.tx_word_ready     (tx_word_ready),
		.phy_pipe_tx_data  (phy_pipe_tx_data),
		.phy_pipe_tx_datak (phy_pipe_tx_datak)
	);

endmodule

// File: hdl/usb3_pkg.sv
// usb3 pipe types
// beat and word structs shared by the receive and transmit paths

package usb3_pkg;

	////////////////////////////////////////
	// PIPE side
	////////////////////////////////////////

	// one 16 bit beat as seen on the PIPE3 pins
	typedef struct packed {
		logic [15:0] data;
		logic [1:0]  datak;     // bit n flags byte n as a K symbol
	} pipe_beat_t;

	////////////////////////////////////////
	// link side
	////////////////////////////////////////

	// two beats, first beat in the low half
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  datak;     // low two flags belong to the first beat
	} link_word_t;

endpackage

// File: hdl/usb3_reset_strap.sv
// usb3 reset and strap control
// syncs the power gated reset and drives PHY straps while the core is held

`timescale 1ns/10ps

`include "usb3_macros.svh"

module usb3_reset_strap (
	input  logic       local_pclk_half,
	input  logic       rst_n,
	input  logic       phy_pwrpresent,
	input  logic [2:0] tx_margin,
	output logic       core_rst_n,
	output logic       phy_phy_reset_n,
	output logic       strap_oe,
	output logic       phy_rx_elecidle_strap,
	output logic       phy_status_strap,
	output logic [2:0] phy_tx_margin
);

	logic sync_1;   // first stage, may go metastable
	logic sync_2;

	// power present is the sync input, rst_n clears both stages at once
	always_ff @(posedge local_pclk_half or negedge rst_n) begin
		if (!rst_n) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
		end else begin
			sync_1 <= phy_pwrpresent;
			sync_2 <= sync_1;
		end
	end

	assign core_rst_n = sync_2;

	// PHY only reset, also drops on cable removal
	assign phy_phy_reset_n = rst_n & phy_pwrpresent;

	////////////////////////////////////////
	// strap pins
	////////////////////////////////////////

	assign strap_oe = ~core_rst_n;     // PHY latches the straps on reset release

	assign phy_tx_margin = core_rst_n ? tx_margin : `USB3_STRAP_MARGIN;

	// only sampled by the PHY while strap_oe is high
	assign phy_rx_elecidle_strap = `USB3_STRAP_ELECIDLE;
	assign phy_status_strap      = `USB3_STRAP_PHYSTAT;

endmodule

// File: include/usb3_macros.svh
// usb3 pipe data path constants
// PIPE and link widths, skid depth and PHY strap values

`ifndef USB3_MACROS_SVH
`define USB3_MACROS_SVH

////////////////////////////////////////
// data widths
////////////////////////////////////////

`define USB3_PIPE_W         16      // PIPE3 sdr beat
`define USB3_PIPE_K_W       2       // one K flag per byte
`define USB3_LINK_W         32      // link word, two beats
`define USB3_LINK_K_W       4

// entries in each link side skid buffer
`define USB3_SKID_DEPTH     2

////////////////////////////////////////
// strap values, sampled by the PHY in reset
////////////////////////////////////////

// tx_margin pins select spread spectrum disable
`define USB3_STRAP_MARGIN   3'b011
// rx_elecidle pin selects the crystal input
`define USB3_STRAP_ELECIDLE 1'b0
// phy_status pin selects the 16 bit sdr pipe
`define USB3_STRAP_PHYSTAT  1'b0

`endif

// File: project.f
+incdir+include
hdl/usb3_pkg.sv
hdl/usb3_reset_strap.sv
hdl/link_skid.sv
hdl/pipe_rx_packer.sv
hdl/pipe_tx_serializer.sv
hdl/usb3_pipe_top.sv
test/tb_usb3_pipe_top.sv

// File: test/tb_usb3_pipe_top.sv
// testbench for the usb3 PIPE3 data path
// directed tests for straps, receive packing, back-pressure, transmit and power loss

`timescale 1ns/10ps

module tb_usb3_pipe_top;

	import usb3_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RX_BEATS   = 20;
	localparam int TX_WORDS   = 24;
	localparam int WAIT_LIMIT = 40;     // cycles allowed for one handshake or drain
	// worst case cycles of each test, summed
	localparam int TEST_CYCLES = 12 + (RX_BEATS * 4 + WAIT_LIMIT) + (12 + 2 * WAIT_LIMIT)
		+ (TX_WORDS + 4) * (WAIT_LIMIT + 3) + 3 * WAIT_LIMIT + 24;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;

	logic        local_pclk_half;
	logic        rst_n;
	logic        phy_pwrpresent;
	logic        phy_reset_n;
	logic        phy_phy_reset_n;
	logic        strap_oe;
	logic        phy_rx_elecidle_strap;
	logic        phy_status_strap;
	logic [2:0]  tx_margin;
	logic [2:0]  phy_tx_margin;
	logic        phy_pipe_rx_valid;
	logic [15:0] phy_pipe_rx_data;
	logic [1:0]  phy_pipe_rx_datak;
	link_word_t  link_rx_word;
	logic        link_rx_valid;
	logic        link_rx_ready;
	logic        rx_overflow;
	link_word_t  link_tx_word;
	logic        link_tx_valid;
	logic        link_tx_ready;
	logic [15:0] phy_pipe_tx_data;
	logic [1:0]  phy_pipe_tx_datak;

	int          errors;
	int          seed;
	int          tx_beat_cnt;       // odd while a word is half sent
	logic        rx_have_lo;        // expected packer phase
	pipe_beat_t  rx_lo;
	link_word_t  rx_exp_q[$];
	pipe_beat_t  tx_exp_q[$];

	usb3_pipe_top u_dut (.*);

	initial begin
		local_pclk_half = 1'b0;
		forever #(CLK_PERIOD / 2) local_pclk_half = ~local_pclk_half;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, tests did not finish, %0d errors", $time, errors);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////
	// check helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("ERROR time=%0t %s", $time, msg);
	endtask

	task automatic check_straps();
		check_value("phy_tx_margin", 64'(3'b011), 64'(phy_tx_margin));
		check_value("strap_oe", 64'(1'b1), 64'(strap_oe));
		check_value("phy_rx_elecidle_strap", 64'(1'b0), 64'(phy_rx_elecidle_strap));
		check_value("phy_status_strap", 64'(1'b0), 64'(phy_status_strap));
	endtask

	// state a core reset leaves behind
	task automatic check_core_cleared();
		check_value("link_rx_valid", 64'(1'b0), 64'(link_rx_valid));
		check_value("rx_overflow", 64'(1'b0), 64'(rx_overflow));
		check_value("phy_pipe_tx_data", 64'(16'h0), 64'(phy_pipe_tx_data));
		check_value("phy_pipe_tx_datak", 64'(2'b00), 64'(phy_pipe_tx_datak));
	endtask

	////////////////////////////////////////
	// monitors, sampled mid cycle
	////////////////////////////////////////

	always @(negedge local_pclk_half) begin
		if (link_rx_valid && link_rx_ready) begin
			assert (rx_exp_q.size() != 0) else report_failure("receive word with none expected");
			if (rx_exp_q.size() != 0)
				check_value("link_rx_word", 64'(rx_exp_q.pop_front()), 64'(link_rx_word));
		end
	end

	always @(negedge local_pclk_half) begin : tx_monitor
		pipe_beat_t beat;
		if (link_tx_valid && link_tx_ready) begin   // accepted on the coming edge
			beat.data  = link_tx_word.data[15:0];
			beat.datak = link_tx_word.datak[1:0];
			tx_exp_q.push_back(beat);
			beat.data  = link_tx_word.data[31:16];
			beat.datak = link_tx_word.datak[3:2];
			tx_exp_q.push_back(beat);
		end
		if (phy_pipe_tx_data != 16'h0 || phy_pipe_tx_datak != 2'b00) begin
			assert (tx_exp_q.size() != 0) else report_failure("transmit beat with no word accepted");
			if (tx_exp_q.size() != 0) begin
				beat = tx_exp_q.pop_front();
				check_value("phy_pipe_tx_data", 64'(beat.data), 64'(phy_pipe_tx_data));
				check_value("phy_pipe_tx_datak", 64'(beat.datak), 64'(phy_pipe_tx_datak));
			end
			tx_beat_cnt++;
		end else begin
			assert (tx_beat_cnt % 2 == 0) else report_failure("idle between the halves of a word");
		end
	end

	////////////////////////////////////////
	// drivers, entered and left 1 ns after a rising edge
	////////////////////////////////////////

	task automatic send_rx_burst(input int beats, input int max_gap, input int keep_words);
		logic [31:0] r;
		link_word_t  w;
		for (int i = 0; i < beats; i++) begin
			r = $random(seed);
			phy_pipe_rx_valid = 1'b0;
			phy_pipe_rx_data  = ~r[15:0];   // junk on invalid beats
			repeat (int'(r[23:16]) % (max_gap + 1)) begin
				@(posedge local_pclk_half);
				#1;
			end
			phy_pipe_rx_valid = 1'b1;
			phy_pipe_rx_data  = r[15:0];
			phy_pipe_rx_datak = r[25:24];
			if (!rx_have_lo) begin
				rx_lo.data  = r[15:0];
				rx_lo.datak = r[25:24];
			end else if ((i / 2) < keep_words) begin
				w.data  = {r[15:0], rx_lo.data};   // first beat in the low half
				w.datak = {r[25:24], rx_lo.datak};
				rx_exp_q.push_back(w);
			end
			rx_have_lo = ~rx_have_lo;
			@(posedge local_pclk_half);
			#1;
		end
		phy_pipe_rx_valid = 1'b0;
	endtask

	task automatic wait_rx_drain();
		int n;
		n = 0;
		while (rx_exp_q.size() != 0 && n < WAIT_LIMIT) begin
			@(posedge local_pclk_half);
			#1;
			n++;
		end
		assert (rx_exp_q.size() == 0) else report_failure("receive words missing after wait");
	endtask

	task automatic send_tx_words(input int words, input int max_gap);
		logic [31:0] r;
		link_word_t  w;
		int          n;
		for (int i = 0; i < words; i++) begin
			r = $random(seed);
			w.data = r;
			if (w.data[15:0] == 16'h0)
				w.data[15:0] = 16'h1;     // both halves stand out from idle
			if (w.data[31:16] == 16'h0)
				w.data[31:16] = 16'h1;
			r = $random(seed);
			w.datak = r[3:0];
			link_tx_word  = w;
			link_tx_valid = 1'b1;
			n = 0;
			do begin
				@(negedge local_pclk_half);
				n++;
			end while (!link_tx_ready && n < WAIT_LIMIT);
			assert (link_tx_ready) else report_failure("link_tx_ready stayed low for a word");
			@(posedge local_pclk_half);
			#1;
			link_tx_valid = 1'b0;
			repeat (int'(r[7:4]) % (max_gap + 1)) begin
				@(posedge local_pclk_half);
				#1;
			end
		end
		n = 0;
		while (tx_exp_q.size() != 0 && n < WAIT_LIMIT) begin
			@(posedge local_pclk_half);
			#1;
			n++;
		end
		assert (tx_exp_q.size() == 0) else report_failure("transmit beats missing on the pins");
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic reset_and_straps();
		@(posedge local_pclk_half);
		#1;
		check_straps();
		check_value("phy_reset_n", 64'(1'b0), 64'(phy_reset_n));
		check_value("phy_phy_reset_n", 64'(1'b0), 64'(phy_phy_reset_n));
		@(posedge local_pclk_half);
		#1;
		rst_n = 1'b1;
		check_straps();     // core still held for two edges
		repeat (4) begin
			@(posedge local_pclk_half);
			#1;
		end
		check_value("strap_oe", 64'(1'b0), 64'(strap_oe));
		check_value("phy_tx_margin", 64'(tx_margin), 64'(phy_tx_margin));
		check_value("phy_reset_n", 64'(1'b1), 64'(phy_reset_n));
		check_value("phy_phy_reset_n", 64'(1'b1), 64'(phy_phy_reset_n));
		check_core_cleared();
	endtask

	task automatic rx_packing();
		link_rx_ready = 1'b1;
		send_rx_burst(RX_BEATS, 3, RX_BEATS / 2);
		wait_rx_drain();
		check_value("rx_overflow", 64'(1'b0), 64'(rx_overflow));
	endtask

	task automatic rx_backpressure();
		link_rx_ready = 1'b0;
		send_rx_burst(8, 0, 3);     // fourth word has nowhere to go
		repeat (4) begin
			@(posedge local_pclk_half);
			#1;
		end
		check_value("rx_overflow", 64'(1'b1), 64'(rx_overflow));
		check_value("link_rx_valid", 64'(1'b1), 64'(link_rx_valid));
		link_rx_ready = 1'b1;
		wait_rx_drain();
		repeat (6) begin
			@(posedge local_pclk_half);
			#1;
		end
		check_value("link_rx_valid", 64'(1'b0), 64'(link_rx_valid));
	endtask

	task automatic power_loss();
		int n;
		phy_pwrpresent = 1'b0;
		#1;
		check_value("phy_phy_reset_n", 64'(1'b0), 64'(phy_phy_reset_n));
		n = 0;
		while (!strap_oe && n < 4) begin
			@(negedge local_pclk_half);
			n++;
		end
		assert (strap_oe) else report_failure("strap_oe did not return after power loss");
		check_straps();
		check_core_cleared();
		@(posedge local_pclk_half);
		#1;
		phy_pwrpresent = 1'b1;
		rx_have_lo     = 1'b0;
		n = 0;
		while (strap_oe && n < 4) begin
			@(negedge local_pclk_half);
			n++;
		end
		@(posedge local_pclk_half);
		#1;
		check_value("strap_oe", 64'(1'b0), 64'(strap_oe));
		check_value("phy_tx_margin", 64'(tx_margin), 64'(phy_tx_margin));
		check_value("phy_phy_reset_n", 64'(1'b1), 64'(phy_phy_reset_n));
		send_rx_burst(8, 1, 4);
		wait_rx_drain();
		check_value("rx_overflow", 64'(1'b0), 64'(rx_overflow));
		send_tx_words(4, 1);
	endtask

	initial begin
		seed              = 32'h7fc;
		errors            = 0;
		tx_beat_cnt       = 0;
		rx_have_lo        = 1'b0;
		rst_n             = 1'b0;
		phy_pwrpresent    = 1'b1;
		tx_margin         = 3'b101;
		phy_pipe_rx_valid = 1'b0;
		phy_pipe_rx_data  = 16'h0;
		phy_pipe_rx_datak = 2'b00;
		link_rx_ready     = 1'b1;
		link_tx_word      = '0;
		link_tx_valid     = 1'b0;

		reset_and_straps();
		rx_packing();
		rx_backpressure();
		send_tx_words(TX_WORDS, 2);
		power_loss();

		$display("closing summary: %0d errors", errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
